/* all.f */
tq_pkg.sv
task_unit_regs.sv
task_op_decode.sv
task_heap.sv
spill_buffer.sv
task_deq_route.sv
task_unit_nonspec.sv
tb_task_unit.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_task_unit -f all.f > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
   cat build.log
   echo "Verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/Vtb_task_unit > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
   exit 0
else
   exit 1
fi

/* spill_buffer.sv */
module spill_buffer (
   input  logic                                 clk,
   input  logic                                 rstn,
   input  logic                                 max_valid,
   input  tq_pkg::task_t                        max_task,
   output logic                                 overflow_valid,
   input  logic                                 overflow_ready,
   output tq_pkg::task_t                        overflow_data,
   output logic [tq_pkg::SPILL_OCC_WIDTH-1:0]   spill_occ
);

   tq_pkg::task_t                      mem [tq_pkg::SPILL_FIFO_DEPTH];
   logic [tq_pkg::SPILL_PTR_WIDTH-1:0] wr_ptr;
   logic [tq_pkg::SPILL_PTR_WIDTH-1:0] rd_ptr;
   logic                               rd_en;

   assign overflow_valid = (spill_occ != '0);
   assign overflow_data = mem[rd_ptr];
   assign rd_en = overflow_valid & overflow_ready;

   always_ff @(posedge clk) begin
      if (max_valid) begin
         mem[wr_ptr] <= max_task;
      end
   end

   // Writer never overruns, decode holds off DEQ_MAX near full
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         spill_occ <= '0;
      end else begin
         if (max_valid) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         spill_occ <= spill_occ + {{(tq_pkg::SPILL_OCC_WIDTH-1){1'b0}}, max_valid}
                      - {{(tq_pkg::SPILL_OCC_WIDTH-1){1'b0}}, rd_en};
      end
   end

endmodule

/* task_deq_route.sv */
module task_deq_route (
   input  tq_pkg::task_t   min_task,
   input  logic            min_valid,
   input  logic            deq_allow,
   input  logic            started,
   input  tq_pkg::ts_t     throttle_ts,
   output logic            task_deq_valid,
   input  logic            task_deq_ready,
   output tq_pkg::task_t   task_deq_data,
   output logic            splitter_deq_valid,
   input  logic            splitter_deq_ready,
   output tq_pkg::task_t   splitter_deq_task,
   output logic            deq_take
);

   logic head_ok;
   logic is_splitter;

   assign head_ok = min_valid & deq_allow;
   assign is_splitter = (min_task.ttype == tq_pkg::TT_SPLITTER);

   // Splitter tasks ignore start and throttle
   assign splitter_deq_valid = head_ok & is_splitter;
   assign task_deq_valid = head_ok & ~is_splitter & started & (min_task.ts < throttle_ts);

   assign task_deq_data = min_task;
   assign splitter_deq_task = min_task;

   assign deq_take = (task_deq_valid & task_deq_ready) |
                     (splitter_deq_valid & splitter_deq_ready);

endmodule

/* task_heap.sv */
module task_heap (
   input  logic                              clk,
   input  logic                              rstn,
   input  tq_pkg::heap_op_e                  heap_op,
   input  tq_pkg::task_t                     insert_task,
   output logic                              heap_ready,
   output tq_pkg::task_t                     min_task,
   output logic                              min_valid,
   output logic [tq_pkg::COUNT_WIDTH-1:0]    n_tasks,
   output tq_pkg::task_t                     max_task,
   output logic                              max_valid,
   output logic                              full,
   output logic                              empty,
   output tq_pkg::ts_t                       lvt
);

   // Slot 0 always holds the earliest task
   tq_pkg::task_t [tq_pkg::HEAP_DEPTH-1:0] slots;
   tq_pkg::task_t [tq_pkg::HEAP_DEPTH-1:0] shifted;
   tq_pkg::task_t [tq_pkg::HEAP_DEPTH-1:0] base;
   tq_pkg::task_t [tq_pkg::HEAP_DEPTH-1:0] inserted;
   logic [tq_pkg::HEAP_DEPTH-1:0]          keep;
   logic [tq_pkg::COUNT_WIDTH-1:0]         count;
   logic [tq_pkg::COUNT_WIDTH-1:0]         base_cnt;
   logic [tq_pkg::COUNT_WIDTH-1:0]         last_idx;
   logic                                   busy;
   logic                                   accept;

   assign heap_ready = ~busy;
   assign accept = heap_ready & (heap_op != tq_pkg::NOP);
   assign last_idx = count - 1'b1;

   // Sorted insertion, new task goes behind equal priorities
   always_comb begin
      shifted = {tq_pkg::task_t'('0), slots[tq_pkg::HEAP_DEPTH-1:1]};
      if (heap_op == tq_pkg::REPLACE) begin
         base = shifted;
         base_cnt = count - 1'b1;
      end else begin
         base = slots;
         base_cnt = count;
      end
      for (int i = 0; i < tq_pkg::HEAP_DEPTH; i++) begin
         keep[i] = (tq_pkg::COUNT_WIDTH'(i) < base_cnt) &&
                   !tq_pkg::task_before(insert_task, base[i]);
      end
      inserted[0] = keep[0] ? base[0] : insert_task;
      for (int i = 1; i < tq_pkg::HEAP_DEPTH; i++) begin
         if (keep[i]) begin
            inserted[i] = base[i];
         end else if (keep[i-1]) begin
            inserted[i] = insert_task;
         end else begin
            inserted[i] = base[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
         count <= '0;
         max_valid <= 1'b0;
      end else begin
         // One recovery cycle after every operation
         busy <= accept;
         max_valid <= accept & (heap_op == tq_pkg::DEQ_MAX);
         if (accept) begin
            case (heap_op)
               tq_pkg::ENQ:                  count <= count + 1'b1;
               tq_pkg::DEQ_MIN, tq_pkg::DEQ_MAX: count <= count - 1'b1;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         case (heap_op)
            tq_pkg::ENQ, tq_pkg::REPLACE: slots <= inserted;
            tq_pkg::DEQ_MIN:              slots <= shifted;
            tq_pkg::DEQ_MAX:              max_task <= slots[last_idx[tq_pkg::HEAP_IDX_WIDTH-1:0]];
            default: ;
         endcase
      end
   end

   assign n_tasks = count;
   assign min_task = slots[0];
   assign min_valid = (count != '0);
   assign empty = (count == '0);
   assign full = (count >= tq_pkg::COUNT_WIDTH'(tq_pkg::HEAP_DEPTH - tq_pkg::FULL_MARGIN));
   assign lvt = empty ? '1 : slots[0].ts;

endmodule

/* task_op_decode.sv */
module task_op_decode (
   input  logic                                 clk,
   input  logic                                 rstn,
   input  logic                                 task_enq_valid,
   output logic                                 task_enq_ready,
   input  tq_pkg::task_t                        task_enq_data,
   input  logic                                 coal_child_valid,
   output logic                                 coal_child_ready,
   input  tq_pkg::task_t                        coal_child_data,
   input  logic [tq_pkg::COUNT_WIDTH-1:0]       n_tasks,
   input  logic [tq_pkg::COUNT_WIDTH-1:0]       spill_threshold,
   input  logic [tq_pkg::COUNT_WIDTH-1:0]       spill_size,
   input  logic                                 heap_ready,
   input  logic [tq_pkg::SPILL_OCC_WIDTH-1:0]   spill_occ,
   input  logic                                 deq_take,
   output tq_pkg::heap_op_e                     heap_op,
   output tq_pkg::task_t                        insert_task,
   output logic                                 deq_allow,
   output logic                                 almost_full
);

   logic [tq_pkg::COUNT_WIDTH-1:0] spill_left;
   logic                           spilling;
   logic                           staged_valid;
   tq_pkg::task_t                  staged_task;
   logic                           can_accept;
   logic                           take_staged;

   assign spilling = (spill_left != '0);
   assign almost_full = (n_tasks > spill_threshold);
   assign deq_allow = heap_ready & ~spilling;
   assign insert_task = staged_task;

   // Child port wins when both sources present a task
   assign can_accept = ~staged_valid & ~spilling;
   assign coal_child_ready = can_accept & coal_child_valid;
   assign task_enq_ready = can_accept & task_enq_valid & ~coal_child_valid;

   always_ff @(posedge clk) begin
      if (coal_child_ready) begin
         staged_task <= coal_child_data;
      end else if (task_enq_ready) begin
         staged_task <= task_enq_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         staged_valid <= 1'b0;
      end else if (coal_child_ready | task_enq_ready) begin
         staged_valid <= 1'b1;
      end else if (take_staged) begin
         staged_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spill_left <= '0;
      end else if (~spilling & almost_full) begin
         spill_left <= spill_size;
      end else if (heap_op == tq_pkg::DEQ_MAX) begin
         spill_left <= spill_left - 1'b1;
      end else if (spilling & (n_tasks == '0)) begin
         // Nothing left to spill
         spill_left <= '0;
      end
   end

   always_comb begin
      heap_op = tq_pkg::NOP;
      if (heap_ready) begin
         if (spilling) begin
            if ((n_tasks != '0) &&
                (spill_occ < tq_pkg::SPILL_OCC_WIDTH'(tq_pkg::SPILL_ISSUE_LIMIT))) begin
               heap_op = tq_pkg::DEQ_MAX;
            end
         end else if (staged_valid & deq_take) begin
            heap_op = tq_pkg::REPLACE;
         end else if (staged_valid && (n_tasks < tq_pkg::COUNT_WIDTH'(tq_pkg::HEAP_DEPTH))) begin
            heap_op = tq_pkg::ENQ;
         end else if (deq_take) begin
            heap_op = tq_pkg::DEQ_MIN;
         end
      end
   end

   assign take_staged = (heap_op == tq_pkg::ENQ) | (heap_op == tq_pkg::REPLACE);

endmodule

/* task_unit_nonspec.sv */
module task_unit_nonspec (
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            task_enq_valid,
   output logic                            task_enq_ready,
   input  tq_pkg::task_t                   task_enq_data,
   input  logic                            coal_child_valid,
   output logic                            coal_child_ready,
   input  tq_pkg::task_t                   coal_child_data,
   output logic                            task_deq_valid,
   input  logic                            task_deq_ready,
   output tq_pkg::task_t                   task_deq_data,
   output logic                            splitter_deq_valid,
   input  logic                            splitter_deq_ready,
   output tq_pkg::task_t                   splitter_deq_task,
   output logic                            overflow_valid,
   input  logic                            overflow_ready,
   output tq_pkg::task_t                   overflow_data,
   input  logic                            cfg_wvalid,
   input  tq_pkg::cfg_addr_e               cfg_waddr,
   input  logic [tq_pkg::CFG_WIDTH-1:0]    cfg_wdata,
   input  tq_pkg::ts_t                     gvt_ts,
   output tq_pkg::ts_t                     lvt,
   output logic                            full,
   output logic                            almost_full,
   output logic                            empty
);

   logic [tq_pkg::COUNT_WIDTH-1:0]     spill_threshold;
   logic [tq_pkg::COUNT_WIDTH-1:0]     spill_size;
   logic                               started;
   tq_pkg::ts_t                        throttle_ts;
   tq_pkg::heap_op_e                   heap_op;
   tq_pkg::task_t                      insert_task;
   logic                               deq_allow;
   logic                               heap_ready;
   tq_pkg::task_t                      min_task;
   logic                               min_valid;
   logic [tq_pkg::COUNT_WIDTH-1:0]     n_tasks;
   tq_pkg::task_t                      max_task;
   logic                               max_valid;
   logic [tq_pkg::SPILL_OCC_WIDTH-1:0] spill_occ;
   logic                               deq_take;

   task_unit_regs regs_i (
      .clk(clk), .rstn(rstn),
      .cfg_wvalid(cfg_wvalid), .cfg_waddr(cfg_waddr), .cfg_wdata(cfg_wdata),
      .gvt_ts(gvt_ts),
      .spill_threshold(spill_threshold), .spill_size(spill_size),
      .started(started), .throttle_ts(throttle_ts)
   );

   task_op_decode decode_i (
      .clk(clk), .rstn(rstn),
      .task_enq_valid(task_enq_valid), .task_enq_ready(task_enq_ready),
      .task_enq_data(task_enq_data),
      .coal_child_valid(coal_child_valid), .coal_child_ready(coal_child_ready),
      .coal_child_data(coal_child_data),
      .n_tasks(n_tasks), .spill_threshold(spill_threshold), .spill_size(spill_size),
      .heap_ready(heap_ready), .spill_occ(spill_occ), .deq_take(deq_take),
      .heap_op(heap_op), .insert_task(insert_task),
      .deq_allow(deq_allow), .almost_full(almost_full)
   );

   task_heap heap_i (
      .clk(clk), .rstn(rstn),
      .heap_op(heap_op), .insert_task(insert_task), .heap_ready(heap_ready),
      .min_task(min_task), .min_valid(min_valid), .n_tasks(n_tasks),
      .max_task(max_task), .max_valid(max_valid),
      .full(full), .empty(empty), .lvt(lvt)
   );

   spill_buffer spill_i (
      .clk(clk), .rstn(rstn),
      .max_valid(max_valid), .max_task(max_task),
      .overflow_valid(overflow_valid), .overflow_ready(overflow_ready),
      .overflow_data(overflow_data), .spill_occ(spill_occ)
   );

   task_deq_route route_i (
      .min_task(min_task), .min_valid(min_valid), .deq_allow(deq_allow),
      .started(started), .throttle_ts(throttle_ts),
      .task_deq_valid(task_deq_valid), .task_deq_ready(task_deq_ready),
      .task_deq_data(task_deq_data),
      .splitter_deq_valid(splitter_deq_valid), .splitter_deq_ready(splitter_deq_ready),
      .splitter_deq_task(splitter_deq_task),
      .deq_take(deq_take)
   );

endmodule

/* task_unit_regs.sv */
module task_unit_regs (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic                             cfg_wvalid,
   input  tq_pkg::cfg_addr_e                cfg_waddr,
   input  logic [tq_pkg::CFG_WIDTH-1:0]     cfg_wdata,
   input  tq_pkg::ts_t                      gvt_ts,
   output logic [tq_pkg::COUNT_WIDTH-1:0]   spill_threshold,
   output logic [tq_pkg::COUNT_WIDTH-1:0]   spill_size,
   output logic                             started,
   output tq_pkg::ts_t                      throttle_ts
);

   tq_pkg::ts_t throttle_margin;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spill_threshold <= tq_pkg::COUNT_WIDTH'(tq_pkg::RST_SPILL_THRESHOLD);
         spill_size <= tq_pkg::COUNT_WIDTH'(tq_pkg::RST_SPILL_SIZE);
         started <= 1'b0;
         throttle_margin <= '0;
      end else if (cfg_wvalid) begin
         case (cfg_waddr)
            tq_pkg::CFG_SPILL_THRESHOLD: spill_threshold <= cfg_wdata[tq_pkg::COUNT_WIDTH-1:0];
            tq_pkg::CFG_SPILL_SIZE:      spill_size <= cfg_wdata[tq_pkg::COUNT_WIDTH-1:0];
            tq_pkg::CFG_START:           started <= cfg_wdata[0];
            tq_pkg::CFG_THROTTLE_MARGIN: throttle_margin <= cfg_wdata;
            default: ;
         endcase
      end
   end

   // Zero margin disables throttling
   always_ff @(posedge clk) begin
      if (throttle_margin == '0) begin
         throttle_ts <= '1;
      end else begin
         throttle_ts <= gvt_ts + throttle_margin;
      end
   end

endmodule

/* tb_task_unit.sv */
module tb_task_unit;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 20;
   // All five tests together need a few hundred cycles at most
   localparam int TIMEOUT_CYCLES = 3000;
   localparam int HOLD_CYCLES = 8;

   logic                         clk;
   logic                         rstn;
   logic                         task_enq_valid;
   logic                         task_enq_ready;
   tq_pkg::task_t                task_enq_data;
   logic                         coal_child_valid;
   logic                         coal_child_ready;
   tq_pkg::task_t                coal_child_data;
   logic                         task_deq_valid;
   logic                         task_deq_ready;
   tq_pkg::task_t                task_deq_data;
   logic                         splitter_deq_valid;
   logic                         splitter_deq_ready;
   tq_pkg::task_t                splitter_deq_task;
   logic                         overflow_valid;
   logic                         overflow_ready;
   tq_pkg::task_t                overflow_data;
   logic                         cfg_wvalid;
   tq_pkg::cfg_addr_e            cfg_waddr;
   logic [tq_pkg::CFG_WIDTH-1:0] cfg_wdata;
   tq_pkg::ts_t                  gvt_ts;
   tq_pkg::ts_t                  lvt;
   logic                         full;
   logic                         almost_full;
   logic                         empty;

   int                           cycle_count = 0;
   // Tasks still held by the DUT, earliest first
   tq_pkg::task_t                expected_q[$];
   tq_pkg::ts_t                  used_ts[$];

   task_unit_nonspec task_unit_nonspec_i (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         stop_on_error($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
      end
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_task(input string name, input tq_pkg::task_t got,
                             input tq_pkg::task_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_ts(input string name, input tq_pkg::ts_t got, input tq_pkg::ts_t exp);
      if (got !== exp) begin
         stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   // Distinct random timestamp, never all ones
   function automatic tq_pkg::ts_t fresh_ts();
      tq_pkg::ts_t ts;
      logic seen;
      do begin
         ts = tq_pkg::ts_t'($urandom % 32'hffff);
         seen = 1'b0;
         foreach (used_ts[i]) begin
            if (used_ts[i] == ts) begin
               seen = 1'b1;
            end
         end
      end while (seen);
      used_ts.push_back(ts);
      return ts;
   endfunction

   function automatic tq_pkg::task_t make_task(input tq_pkg::ts_t ts,
                                               input tq_pkg::task_type_e ttype);
      tq_pkg::task_t t;
      t.ts = ts;
      t.producer = 1'($urandom);
      t.ttype = ttype;
      t.locale = 16'($urandom);
      t.args = 16'($urandom);
      return t;
   endfunction

   task automatic add_expected(input tq_pkg::task_t t);
      int pos;
      pos = 0;
      while (pos < expected_q.size() && expected_q[pos].ts < t.ts) begin
         pos++;
      end
      expected_q.insert(pos, t);
   endtask

   task automatic cfg_write(input tq_pkg::cfg_addr_e addr, input logic [15:0] data);
      cfg_wvalid = 1'b1;
      cfg_waddr = addr;
      cfg_wdata = data;
      @(negedge clk);
      cfg_wvalid = 1'b0;
   endtask

   task automatic send_task(input logic child, input tq_pkg::task_t t);
      logic got;
      if (child) begin
         coal_child_valid = 1'b1;
         coal_child_data = t;
      end else begin
         task_enq_valid = 1'b1;
         task_enq_data = t;
      end
      got = 1'b0;
      while (!got) begin
         #1;
         got = child ? coal_child_ready : task_enq_ready;
         if (!got) begin
            @(negedge clk);
         end
      end
      @(negedge clk);
      coal_child_valid = 1'b0;
      task_enq_valid = 1'b0;
   endtask

   // Accept the next head on one port, the other port must stay quiet
   task automatic expect_head(input logic splitter, input tq_pkg::task_t exp);
      logic got;
      task_deq_ready = ~splitter;
      splitter_deq_ready = splitter;
      got = 1'b0;
      while (!got) begin
         #1;
         if (splitter) begin
            check_bit("task_deq_valid", task_deq_valid, 1'b0);
            got = splitter_deq_valid;
         end else begin
            check_bit("splitter_deq_valid", splitter_deq_valid, 1'b0);
            got = task_deq_valid;
         end
         if (!got) begin
            @(negedge clk);
         end
      end
      if (splitter) begin
         check_task("splitter_deq_task", splitter_deq_task, exp);
      end else begin
         check_task("task_deq_data", task_deq_data, exp);
      end
      check_ts("lvt", lvt, exp.ts);
      @(negedge clk);
      task_deq_ready = 1'b0;
      splitter_deq_ready = 1'b0;
   endtask

   task automatic expect_overflow(input tq_pkg::task_t exp);
      logic got;
      overflow_ready = 1'b1;
      got = 1'b0;
      while (!got) begin
         #1;
         got = overflow_valid;
         if (!got) begin
            @(negedge clk);
         end
      end
      check_task("overflow_data", overflow_data, exp);
      @(negedge clk);
      overflow_ready = 1'b0;
   endtask

   task automatic expect_no_offer(input int cycles);
      task_deq_ready = 1'b1;
      splitter_deq_ready = 1'b1;
      repeat (cycles) begin
         #1;
         check_bit("task_deq_valid", task_deq_valid, 1'b0);
         check_bit("splitter_deq_valid", splitter_deq_valid, 1'b0);
         @(negedge clk);
      end
      task_deq_ready = 1'b0;
      splitter_deq_ready = 1'b0;
   endtask

   // Head is the earliest task once every staged task has landed
   task automatic wait_for_lvt(input tq_pkg::ts_t ts);
      #1;
      while (lvt !== ts) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
   endtask

   // Task count above the threshold shows up once the last task lands
   task automatic wait_for_almost_full();
      int waited;
      waited = 0;
      #1;
      while (almost_full !== 1'b1) begin
         waited++;
         if (waited > HOLD_CYCLES) begin
            stop_on_error("almost_full did not assert after the task count passed the threshold");
         end
         @(negedge clk);
         #1;
      end
      @(negedge clk);
   endtask

   task automatic expect_empty();
      #1;
      check_bit("empty", empty, 1'b1);
      check_ts("lvt", lvt, '1);
      @(negedge clk);
   endtask

   task automatic test_reset_values();
      #1;
      check_bit("task_deq_valid", task_deq_valid, 1'b0);
      check_bit("splitter_deq_valid", splitter_deq_valid, 1'b0);
      check_bit("overflow_valid", overflow_valid, 1'b0);
      check_bit("task_enq_ready", task_enq_ready, 1'b0);
      check_bit("coal_child_ready", coal_child_ready, 1'b0);
      check_bit("full", full, 1'b0);
      check_bit("almost_full", almost_full, 1'b0);
      check_bit("empty", empty, 1'b1);
      check_ts("lvt", lvt, '1);
      @(negedge clk);
   endtask

   task automatic test_ordered_dequeue();
      tq_pkg::task_t t;
      repeat (5) begin
         t = make_task(fresh_ts(), tq_pkg::TT_WORK);
         add_expected(t);
         send_task(1'b0, t);
      end
      wait_for_lvt(expected_q[0].ts);
      cfg_write(tq_pkg::CFG_START, 16'd1);
      while (expected_q.size() != 0) begin
         t = expected_q.pop_front();
         expect_head(1'b0, t);
      end
      expect_empty();
   endtask

   task automatic test_priority_and_splitter();
      tq_pkg::ts_t a;
      tq_pkg::ts_t b;
      tq_pkg::task_t split_task;
      tq_pkg::task_t work_task;
      cfg_write(tq_pkg::CFG_START, 16'd0);
      a = fresh_ts();
      b = fresh_ts();
      split_task = make_task((a < b) ? a : b, tq_pkg::TT_SPLITTER);
      work_task = make_task((a < b) ? b : a, tq_pkg::TT_WORK);
      // Both sources in the same cycle
      coal_child_valid = 1'b1;
      coal_child_data = split_task;
      task_enq_valid = 1'b1;
      task_enq_data = work_task;
      #1;
      check_bit("coal_child_ready", coal_child_ready, 1'b1);
      check_bit("task_enq_ready", task_enq_ready, 1'b0);
      @(negedge clk);
      coal_child_valid = 1'b0;
      send_task(1'b0, work_task);
      expect_head(1'b1, split_task);
      expect_no_offer(HOLD_CYCLES);
      cfg_write(tq_pkg::CFG_START, 16'd1);
      expect_head(1'b0, work_task);
      expect_empty();
   endtask

   task automatic test_throttle();
      tq_pkg::task_t t;
      tq_pkg::ts_t   ts_list[4];
      ts_list = '{16'd1100, 16'd1010, 16'd1050, 16'd1030};
      cfg_write(tq_pkg::CFG_THROTTLE_MARGIN, 16'd50);
      gvt_ts = 16'd1000;
      // Bound is 1050, the task at 1050 itself must wait
      foreach (ts_list[i]) begin
         t = make_task(ts_list[i], tq_pkg::TT_WORK);
         add_expected(t);
         send_task(1'b0, t);
      end
      repeat (2) begin
         t = expected_q.pop_front();
         expect_head(1'b0, t);
      end
      expect_no_offer(HOLD_CYCLES);
      gvt_ts = 16'd1200;
      while (expected_q.size() != 0) begin
         t = expected_q.pop_front();
         expect_head(1'b0, t);
      end
      expect_empty();
      cfg_write(tq_pkg::CFG_THROTTLE_MARGIN, 16'd0);
   endtask

   task automatic test_spill();
      tq_pkg::task_t t;
      cfg_write(tq_pkg::CFG_START, 16'd0);
      repeat (6) begin
         t = make_task(fresh_ts(), tq_pkg::TT_WORK);
         add_expected(t);
         send_task(1'b0, t);
      end
      wait_for_almost_full();
      // Latest two leave through overflow, largest first
      repeat (2) begin
         t = expected_q.pop_back();
         expect_overflow(t);
      end
      #1;
      check_bit("almost_full", almost_full, 1'b0);
      @(negedge clk);
      cfg_write(tq_pkg::CFG_START, 16'd1);
      while (expected_q.size() != 0) begin
         t = expected_q.pop_front();
         expect_head(1'b0, t);
      end
      expect_empty();
      #1;
      check_bit("overflow_valid", overflow_valid, 1'b0);
      @(negedge clk);
   endtask

   initial begin
      void'($urandom(32'hcd9c4b33));
      clk = 1'b0;
      rstn = 1'b0;
      task_enq_valid = 1'b0;
      task_enq_data = '0;
      coal_child_valid = 1'b0;
      coal_child_data = '0;
      task_deq_ready = 1'b0;
      splitter_deq_ready = 1'b0;
      overflow_ready = 1'b0;
      cfg_wvalid = 1'b0;
      cfg_waddr = tq_pkg::CFG_SPILL_THRESHOLD;
      cfg_wdata = '0;
      gvt_ts = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      test_reset_values();
      test_ordered_dequeue();
      test_priority_and_splitter();
      test_throttle();
      test_spill();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* tq_pkg.sv */
package tq_pkg;

   localparam int TS_WIDTH = 16;
   localparam int CFG_WIDTH = 16;

   localparam int HEAP_DEPTH = 8;
   localparam int HEAP_IDX_WIDTH = $clog2(HEAP_DEPTH);
   localparam int COUNT_WIDTH = 4;
   // Free slots left when full asserts
   localparam int FULL_MARGIN = 1;

   localparam int SPILL_FIFO_DEPTH = 4;
   localparam int SPILL_PTR_WIDTH = $clog2(SPILL_FIFO_DEPTH);
   localparam int SPILL_OCC_WIDTH = SPILL_PTR_WIDTH + 1;
   // Leaves room for the one maximum still in flight from the store
   localparam int SPILL_ISSUE_LIMIT = 3;

   localparam int RST_SPILL_THRESHOLD = 5;
   localparam int RST_SPILL_SIZE = 2;

   typedef logic [TS_WIDTH-1:0] ts_t;

   typedef enum logic [3:0] {
      TT_WORK     = 4'd0,
      TT_READ     = 4'd1,
      TT_SPLITTER = 4'd2
   } task_type_e;

   typedef struct packed {
      ts_t        ts;
      logic       producer;
      task_type_e ttype;
      logic [15:0] locale;
      logic [15:0] args;
   } task_t;

   typedef enum logic [2:0] {
      NOP     = 3'd0,
      ENQ     = 3'd1,
      DEQ_MIN = 3'd2,
      REPLACE = 3'd3,
      DEQ_MAX = 3'd4
   } heap_op_e;

   typedef enum logic [1:0] {
      CFG_SPILL_THRESHOLD = 2'd0,
      CFG_SPILL_SIZE      = 2'd1,
      CFG_START           = 2'd2,
      CFG_THROTTLE_MARGIN = 2'd3
   } cfg_addr_e;

   // Priority order: timestamp first, producer breaks ties
   function automatic logic task_before(task_t a, task_t b);
      return {a.ts, a.producer} < {b.ts, b.producer};
   endfunction

endpackage
